//--- dv/cpu_patterns.hex
// Header: program length in words, expected retire count
// Then program words from pc 0, then records of pc, {we, rd}, data
0023 001F
// Program, ALU and immediates
B105 B203 0312 1421 A112 2631 3764 4878
// r0 write and read, stores, loads with load-use
0012 0901 9302 0A33 9A03 8B02 0CBA 8DBB
1EDB 1FBE
// Branch EQ taken, EQ not taken, LT taken over an HLT
C202 B1EE B2EE 011B C201 12D8 C603 F000
B3EE B3EE
// Two-pass loop with NE back, then HLT
B502 BF01 155F C1FE B777 F000 B8EE
// Expected retire records
0000 0011 0005
0002 0012 0003
0004 0013 0008
0006 0014 FFFE
0008 0011 1205
000A 0016 120D
000C 0017 20D0
000E 0018 0020
0010 0000 0000 // write to r0
0012 0019 1205
0014 0000 0000
0016 001A 0010
0018 0000 0000
001A 001B 0008
001C 001C 0018
001E 001D 0010
0020 001E 0008
0022 001F 0000
0024 0000 0000 // skips 0026 and 0028
002A 0011 120D
002C 0000 0000
002E 0012 FFF0
0030 0000 0000 // skips to 0038
0038 0015 0002
003A 001F 0001
003C 0015 0001
003E 0000 0000
003C 0015 0000
003E 0000 0000
0040 0017 2077
0042 0000 0000 // HLT

//--- dv/cpu_tb.sv
`include "cpu_macros.svh"
`default_nettype none

module cpu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int HDR_WORDS    = 2;
	localparam int PAT_WORDS    = 512;
	localparam int IMEM_WORDS   = 256;
	localparam int TAIL_CYCLES  = 8;

	logic                 clk;
	logic                 arst_n;
	logic [`CPU_XLEN-1:0] instr;
	logic [`CPU_XLEN-1:0] pc_out;
	logic                 hlt;
	retire_t              retire;

	// Raw data file and the instruction memory model
	logic [`CPU_XLEN-1:0] pat [PAT_WORDS];
	logic [`CPU_XLEN-1:0] imem [IMEM_WORDS];

	int                   prog_len;
	int                   retire_total;
	int                   rec_base;
	int                   retired;
	int                   cycles;
	int                   cycle_limit;
	int                   value_errors;
	int                   other_errors;
	bit                   halt_seen;
	bit                   run_done;
	logic [`CPU_XLEN-1:0] halt_pc;

	cpu i_cpu (
		.clk   (clk),
		.arst_n(arst_n),
		.instr (instr),
		.pc_out(pc_out),
		.hlt   (hlt),
		.retire(retire)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check_field(input string name, input logic [`CPU_XLEN-1:0] got,
		input logic [`CPU_XLEN-1:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_patterns();
		$readmemh("dv/cpu_patterns.hex", pat);
		prog_len     = int'(pat[0]);
		retire_total = int'(pat[1]);
		rec_base     = HDR_WORDS + prog_len;
		// Reset, then roughly four cycles per word and per record
		cycle_limit  = RESET_CYCLES + 4 * (prog_len + retire_total);
		// Unused words decode as HLT, tagged with their index
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = {8'hF0, 8'(i)};
		end
		for (int i = 0; i < prog_len; i++) begin
			imem[i] = pat[HDR_WORDS + i];
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		// Core idle while held in reset
		check_field("pc_out", pc_out, 16'h0);
		check_field("hlt", 16'(hlt), 16'h0);
		check_field("retire.valid", 16'(retire.valid), 16'h0);
		arst_n = 1'b1;
	endtask

	// One record per strobe, in program order
	task automatic check_retire();
		logic [`CPU_XLEN-1:0] exp_pc;
		logic [`CPU_XLEN-1:0] exp_wr;
		logic [`CPU_XLEN-1:0] exp_data;
		logic                 is_halt;
		assert (retired < retire_total) else begin
			other_errors++;
			$display("Retire strobe at %0t ns beyond the %0d expected records",
				$time, retire_total);
		end
		if (retired < retire_total) begin
			exp_pc   = pat[rec_base + 3 * retired];
			exp_wr   = pat[rec_base + 3 * retired + 1];
			exp_data = pat[rec_base + 3 * retired + 2];
			// Opcode F at the expected pc
			is_halt  = (imem[exp_pc[8:1]][15:12] == 4'hF);
			check_field("retire.pc", retire.pc, exp_pc);
			check_field("retire.we", 16'(retire.we), 16'(exp_wr[4]));
			// rd and data only for register writes
			if (exp_wr[4]) begin
				check_field("retire.rd", 16'(retire.rd), 16'(exp_wr[3:0]));
				check_field("retire.data", retire.data, exp_data);
			end
			// hlt rises with the HLT in write-back
			check_field("hlt", 16'(hlt), 16'(is_halt));
			if (is_halt) begin
				halt_seen = 1'b1;
				halt_pc   = exp_pc;
			end
			retired++;
		end
	endtask

	// Quiet core, pc parked one word past the HLT
	task automatic check_halted();
		assert (!retire.valid) else begin
			other_errors++;
			$display("Retire strobe at %0t ns after the HLT retired", $time);
		end
		check_field("hlt", 16'(hlt), 16'h1);
		check_field("pc_out", pc_out, halt_pc + 16'd2);
	endtask

	task automatic finish_run();
		$display("Errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// ------------------------------
	// Stimulus and monitors
	// ------------------------------
	// Word fetch, pc counts bytes
	always @(negedge clk) begin
		instr = imem[pc_out[8:1]];
	end

	always @(posedge clk) begin
		if (arst_n) begin
			if (halt_seen) begin
				check_halted();
			end else if (retire.valid) begin
				check_retire();
			end else begin
				check_field("hlt", 16'(hlt), 16'h0);
			end
		end
	end

	// Cycle budget
	always @(posedge clk) begin
		cycles++;
		if (!run_done && cycle_limit > 0 && cycles >= cycle_limit) begin
			other_errors++;
			$display("Timeout after %0d cycles with %0d of %0d records retired",
				cycles, retired, retire_total);
			run_done = 1'b1;
			finish_run();
		end
	end

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		instr        = '0;
		cycles       = 0;
		cycle_limit  = 0;
		retired      = 0;
		value_errors = 0;
		other_errors = 0;
		halt_seen    = 1'b0;
		run_done     = 1'b0;
		halt_pc      = '0;
		load_patterns();
		apply_reset();
		wait (halt_seen);
		// Watch for stray strobes after the HLT
		repeat (TAIL_CYCLES) @(posedge clk);
		assert (retired == retire_total) else begin
			other_errors++;
			$display("Retired %0d records, expected %0d", retired, retire_total);
		end
		if (!run_done) begin
			run_done = 1'b1;
			finish_run();
		end
	end

endmodule

`default_nettype wire

//--- hw/alu.sv
`include "cpu_macros.svh"
`default_nettype none

module alu (
	input  wire cpu_pkg::opcode_e     op,
	input  wire logic [`CPU_XLEN-1:0] a,
	input  wire logic [`CPU_XLEN-1:0] b,
	output logic [`CPU_XLEN-1:0]      result,
	output cpu_pkg::flags_t           flags,
	output cpu_pkg::flags_t           flag_mask
);

	import cpu_pkg::*;

	localparam int MSB = `CPU_XLEN - 1;

	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic                 add_ovf;
	logic                 sub_ovf;

	assign sum  = a + b;
	assign diff = a - b;

	// Signed overflow, operands alike in sign and result differs
	assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	// Subtract flips the sign test on b
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	always_comb begin
		result    = '0;
		flags     = '0;
		flag_mask = '0;
		case (op)
			OP_ADD: begin
				result    = sum;
				flags.v   = add_ovf;
				flag_mask = '{z: 1'b1, v: 1'b1, n: 1'b1};
			end
			OP_SUB: begin
				result    = diff;
				flags.v   = sub_ovf;
				flag_mask = '{z: 1'b1, v: 1'b1, n: 1'b1};
			end
			// Logic and shifts touch Z only
			OP_XOR: begin
				result      = a ^ b;
				flag_mask.z = 1'b1;
			end
			OP_SLL: begin
				result      = a << b[3:0];
				flag_mask.z = 1'b1;
			end
			OP_SRL: begin
				result      = a >> b[3:0];
				flag_mask.z = 1'b1;
			end
			default: ;
		endcase
		flags.z = (result == '0);
		flags.n = result[MSB];
	end

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`include "cpu_macros.svh"
`default_nettype none

module branch_unit (
	input  wire logic                 is_branch,
	input  wire cpu_pkg::cond_e       cond,
	input  wire cpu_pkg::flags_t      flags,
	input  wire logic [`CPU_XLEN-1:0] pc,
	input  wire logic [8:0]           offset,
	output logic                      taken,
	output logic [`CPU_XLEN-1:0]      target
);

	import cpu_pkg::*;

	logic                 cond_met;
	logic [`CPU_XLEN-1:0] pc_plus2;
	logic [`CPU_XLEN-1:0] offset_bytes;

	// Condition table against Z, V, N
	always_comb begin
		case (cond)
			COND_NE: cond_met = !flags.z;
			COND_EQ: cond_met = flags.z;
			COND_GT: cond_met = !flags.z && !flags.n;
			COND_LT: cond_met = flags.n;
			COND_GE: cond_met = flags.z || !flags.n;
			COND_LE: cond_met = flags.z || flags.n;
			COND_OV: cond_met = flags.v;
			default: cond_met = 1'b1;
		endcase
	end

	// Word offset, sign extended and scaled to bytes
	assign offset_bytes = {{(`CPU_XLEN-10){offset[8]}}, offset, 1'b0};
	assign pc_plus2     = pc + `CPU_XLEN'd2;
	assign target       = pc_plus2 + offset_bytes;

	// Non-branches never redirect
	assign taken = is_branch && cond_met;

endmodule

`default_nettype wire

//--- hw/cpu.sv
`include "cpu_macros.svh"
`default_nettype none

module cpu (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic [`CPU_XLEN-1:0] instr,
	output logic [`CPU_XLEN-1:0]      pc_out,
	output logic                      hlt,
	output cpu_pkg::retire_t          retire
);

	import cpu_pkg::*;

	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

	logic [`CPU_XLEN-1:0] pc_q;
	logic [`CPU_XLEN-1:0] pc_d;
	logic                 stall;
	logic                 flush;
	logic                 halt_fetch;
	logic                 branch_taken;
	logic [`CPU_XLEN-1:0] branch_target;
	fwd_e                 fwd_rs;
	fwd_e                 fwd_rt;

	if_id_t  if_id_d;
	if_id_t  if_id_q;
	id_ex_t  id_ex_d;
	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb_q;

	opcode_e              id_op;
	reg_idx_t             id_rd;
	reg_idx_t             rs_addr;
	reg_idx_t             rt_addr;
	logic [`CPU_XLEN-1:0] rs_data;
	logic [`CPU_XLEN-1:0] rt_data;

	logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
	logic [DMEM_AW-1:0]   dmem_idx;
	logic [`CPU_XLEN-1:0] mem_data;

	// ------------------------------
	// Fetch
	// ------------------------------
	// Redirect first, then hold on stall or halt
	always_comb begin
		if (branch_taken) begin
			pc_d = branch_target;
		end else if (stall || halt_fetch) begin
			pc_d = pc_q;
		end else begin
			pc_d = pc_q + `CPU_XLEN'd2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc_out = pc_q;

	// Bubble behind a decoded HLT
	always_comb begin
		if_id_d = '0;
		if (!halt_fetch) begin
			if_id_d.valid = 1'b1;
			if_id_d.pc    = pc_q;
			if_id_d.instr = instr;
		end
	end

	pipe_reg #(.payload_t(if_id_t)) i_if_id (
		.clk   (clk),
		.arst_n(arst_n),
		.en    (!stall),
		.flush (flush),
		.d     (if_id_d),
		.q     (if_id_q)
	);

	// ------------------------------
	// Decode
	// ------------------------------
	assign id_op   = opcode_e'(if_id_q.instr[15:12]);
	assign id_rd   = if_id_q.instr[11:8];
	assign rs_addr = rs_field(if_id_q.instr);
	assign rt_addr = rt_field(if_id_q.instr);

	// Written from write-back
	reg_file i_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.we     (mem_wb_q.valid && mem_wb_q.reg_write),
		.wr_addr(mem_wb_q.rd),
		.wr_data(mem_wb_q.data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	// Control bits only for valid slots, writes to r0 dropped
	always_comb begin
		id_ex_d         = '0;
		id_ex_d.valid   = if_id_q.valid;
		id_ex_d.pc      = if_id_q.pc;
		id_ex_d.instr   = if_id_q.instr;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.rs      = rs_addr;
		id_ex_d.rt      = rt_addr;
		id_ex_d.rd      = id_rd;
		if (if_id_q.valid) begin
			case (id_op)
				OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRL, OP_LHB, OP_LLB: begin
					id_ex_d.reg_write = (id_rd != '0);
				end
				OP_LW: begin
					id_ex_d.mem_read  = 1'b1;
					id_ex_d.reg_write = (id_rd != '0);
				end
				OP_SW:   id_ex_d.mem_write = 1'b1;
				OP_HLT:  id_ex_d.halt = 1'b1;
				default: ;
			endcase
		end
	end

	// Stall leaves a bubble in execute
	pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
		.clk   (clk),
		.arst_n(arst_n),
		.en    (1'b1),
		.flush (flush || stall),
		.d     (id_ex_d),
		.q     (id_ex_q)
	);

	// ------------------------------
	// Execute
	// ------------------------------
	ex_stage i_ex_stage (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex           (id_ex_q),
		.fwd_rs       (fwd_rs),
		.fwd_rt       (fwd_rt),
		.mem_result   (mem_data),
		.wb_result    (mem_wb_q.data),
		.out          (ex_mem_d),
		.branch_taken (branch_taken),
		.branch_target(branch_target)
	);

	pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
		.clk   (clk),
		.arst_n(arst_n),
		.en    (1'b1),
		.flush (1'b0),
		.d     (ex_mem_d),
		.q     (ex_mem_q)
	);

	// ------------------------------
	// Memory
	// ------------------------------
	assign dmem_idx = ex_mem_q.result[DMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (ex_mem_q.valid && ex_mem_q.mem_write) begin
			dmem[dmem_idx] <= ex_mem_q.store_data;
		end
	end

	// Combinational load, else the execute result
	assign mem_data = ex_mem_q.mem_read ? dmem[dmem_idx] : ex_mem_q.result;

	assign mem_wb_d = '{
		valid:     ex_mem_q.valid,
		pc:        ex_mem_q.pc,
		data:      mem_data,
		rd:        ex_mem_q.rd,
		reg_write: ex_mem_q.reg_write,
		halt:      ex_mem_q.halt
	};

	pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
		.clk   (clk),
		.arst_n(arst_n),
		.en    (1'b1),
		.flush (1'b0),
		.d     (mem_wb_d),
		.q     (mem_wb_q)
	);

	// ------------------------------
	// Write-back and retire
	// ------------------------------
	// Data reads zero when nothing is written
	assign retire = '{
		valid: mem_wb_q.valid,
		pc:    mem_wb_q.pc,
		we:    mem_wb_q.reg_write,
		rd:    mem_wb_q.rd,
		data:  mem_wb_q.reg_write ? mem_wb_q.data : '0
	};

	hazard_unit i_hazard_unit (
		.clk         (clk),
		.arst_n      (arst_n),
		.id          (if_id_q),
		.ex          (id_ex_q),
		.mem         (ex_mem_q),
		.wb          (mem_wb_q),
		.branch_taken(branch_taken),
		.stall       (stall),
		.flush       (flush),
		.halt_fetch  (halt_fetch),
		.hlt         (hlt),
		.fwd_rs      (fwd_rs),
		.fwd_rt      (fwd_rt)
	);

endmodule

`default_nettype wire

//--- hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`default_nettype none

// Core sizing

// Data path and address width in bits
`define CPU_XLEN 16

// Architectural registers, r0 included
`define CPU_NREGS 16

// Data memory depth in words
`define CPU_DMEM_WORDS 256

`default_nettype wire

`endif

//--- hw/cpu_pkg.sv
`include "cpu_macros.svh"
`default_nettype none

package cpu_pkg;

	// Opcode field, instr[15:12]
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h3,
		OP_SRL = 4'h4,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_HLT = 4'hF
	} opcode_e;

	// Branch condition, instr[11:9]
	typedef enum logic [2:0] {
		COND_NE = 3'b000,
		COND_EQ = 3'b001,
		COND_GT = 3'b010,
		COND_LT = 3'b011,
		COND_GE = 3'b100,
		COND_LE = 3'b101,
		COND_OV = 3'b110,
		COND_UN = 3'b111
	} cond_e;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_e;

	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// Fetch to decode
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] instr;
	} if_id_t;

	// Decode to execute
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] instr;
		logic [`CPU_XLEN-1:0] rs_data;
		logic [`CPU_XLEN-1:0] rt_data;
		reg_idx_t             rs;
		reg_idx_t             rt;
		reg_idx_t             rd;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 halt;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] result;
		logic [`CPU_XLEN-1:0] store_data;
		reg_idx_t             rd;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 halt;
	} ex_mem_t;

	// Memory to write-back
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] data;
		reg_idx_t             rd;
		logic                 reg_write;
		logic                 halt;
	} mem_wb_t;

	// Commit record, one per completed instruction
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic                 we;
		reg_idx_t             rd;
		logic [`CPU_XLEN-1:0] data;
	} retire_t;

	// First read port, LHB and LLB read their own rd
	function automatic reg_idx_t rs_field(logic [`CPU_XLEN-1:0] instr);
		opcode_e op;
		op = opcode_e'(instr[15:12]);
		return (op == OP_LHB || op == OP_LLB) ? instr[11:8] : instr[7:4];
	endfunction

	// Second read port, stores read their data register
	function automatic reg_idx_t rt_field(logic [`CPU_XLEN-1:0] instr);
		opcode_e op;
		op = opcode_e'(instr[15:12]);
		return (op == OP_SW) ? instr[11:8] : instr[3:0];
	endfunction

endpackage

`default_nettype wire

//--- hw/ex_stage.sv
`include "cpu_macros.svh"
`default_nettype none

module ex_stage (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire cpu_pkg::id_ex_t      ex,
	input  wire cpu_pkg::fwd_e        fwd_rs,
	input  wire cpu_pkg::fwd_e        fwd_rt,
	input  wire logic [`CPU_XLEN-1:0] mem_result,
	input  wire logic [`CPU_XLEN-1:0] wb_result,
	output cpu_pkg::ex_mem_t          out,
	output logic                      branch_taken,
	output logic [`CPU_XLEN-1:0]      branch_target
);

	import cpu_pkg::*;

	opcode_e              op;
	logic [`CPU_XLEN-1:0] rs_val;
	logic [`CPU_XLEN-1:0] rt_val;
	logic [`CPU_XLEN-1:0] alu_b;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] mem_addr;
	logic [`CPU_XLEN-1:0] result;
	flags_t               alu_flags;
	flags_t               alu_mask;
	flags_t               flags_q;

	assign op = opcode_e'(ex.instr[15:12]);

	// ------------------------------
	// Operand forwarding
	// ------------------------------
	always_comb begin
		case (fwd_rs)
			FWD_MEM: rs_val = mem_result;
			FWD_WB:  rs_val = wb_result;
			default: rs_val = ex.rs_data;
		endcase
		case (fwd_rt)
			FWD_MEM: rt_val = mem_result;
			FWD_WB:  rt_val = wb_result;
			default: rt_val = ex.rt_data;
		endcase
	end

	// Shift amount from instr[3:0]
	assign alu_b = (op == OP_SLL || op == OP_SRL) ?
		{{(`CPU_XLEN-4){1'b0}}, ex.instr[3:0]} : rt_val;

	alu i_alu (
		.op       (op),
		.a        (rs_val),
		.b        (alu_b),
		.result   (alu_result),
		.flags    (alu_flags),
		.flag_mask(alu_mask)
	);

	// ------------------------------
	// Flag register
	// ------------------------------
	// Per-flag write that bubbles leave alone
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= '0;
		end else if (ex.valid) begin
			if (alu_mask.z) flags_q.z <= alu_flags.z;
			if (alu_mask.v) flags_q.v <= alu_flags.v;
			if (alu_mask.n) flags_q.n <= alu_flags.n;
		end
	end

	// Bubbles are all zeros and never decode as a branch
	branch_unit i_branch_unit (
		.is_branch(op == OP_B),
		.cond     (cond_e'(ex.instr[11:9])),
		.flags    (flags_q),
		.pc       (ex.pc),
		.offset   (ex.instr[8:0]),
		.taken    (branch_taken),
		.target   (branch_target)
	);

	// ------------------------------
	// Result merge
	// ------------------------------
	// Word address from base plus signed offset
	assign mem_addr = rs_val + {{(`CPU_XLEN-4){ex.instr[3]}}, ex.instr[3:0]};

	always_comb begin
		case (op)
			OP_LHB:       result = {ex.instr[7:0], rs_val[7:0]};
			OP_LLB:       result = {rs_val[`CPU_XLEN-1:8], ex.instr[7:0]};
			OP_LW, OP_SW: result = mem_addr;
			default:      result = alu_result;
		endcase
	end

	// Store data rides the forwarded rt value
	assign out = '{
		valid:      ex.valid,
		pc:         ex.pc,
		result:     result,
		store_data: rt_val,
		rd:         ex.rd,
		reg_write:  ex.reg_write,
		mem_read:   ex.mem_read,
		mem_write:  ex.mem_write,
		halt:       ex.halt
	};

	// No branch opcode in an empty slot
	a_taken_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		branch_taken |-> ex.valid
	);

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire cpu_pkg::if_id_t  id,
	input  wire cpu_pkg::id_ex_t  ex,
	input  wire cpu_pkg::ex_mem_t mem,
	input  wire cpu_pkg::mem_wb_t wb,
	input  wire logic             branch_taken,
	output logic                  stall,
	output logic                  flush,
	output logic                  halt_fetch,
	output logic                  hlt,
	output cpu_pkg::fwd_e         fwd_rs,
	output cpu_pkg::fwd_e         fwd_rt
);

	import cpu_pkg::*;

	opcode_e id_op;
	logic    uses_rs;
	logic    uses_rt;
	logic    load_use;
	logic    id_halt;
	logic    hlt_q;

	// Nearest producer wins and r0 is never forwarded
	function automatic fwd_e pick_fwd(reg_idx_t src, ex_mem_t m, mem_wb_t w);
		if (src == '0) return FWD_NONE;
		if (m.valid && m.reg_write && m.rd == src) return FWD_MEM;
		if (w.valid && w.reg_write && w.rd == src) return FWD_WB;
		return FWD_NONE;
	endfunction

	assign fwd_rs = pick_fwd(ex.rs, mem, wb);
	assign fwd_rt = pick_fwd(ex.rt, mem, wb);

	// Source usage of the instruction in decode
	assign id_op   = opcode_e'(id.instr[15:12]);
	assign uses_rs = !(id_op inside {OP_B, OP_HLT});
	assign uses_rt = id_op inside {OP_ADD, OP_SUB, OP_XOR, OP_SW};

	// Load in execute feeding decode
	assign load_use = id.valid && ex.valid && ex.mem_read && ex.rd != '0 &&
		((uses_rs && ex.rd == rs_field(id.instr)) ||
		 (uses_rt && ex.rd == rt_field(id.instr)));

	// Branch flush overrides stall
	assign flush = branch_taken;
	assign stall = load_use && !branch_taken;

	// HLT in decode counts unless flushed by an older branch
	assign id_halt    = id.valid && id_op == OP_HLT && !branch_taken;
	assign halt_fetch = id_halt || (ex.valid && ex.halt) || (mem.valid && mem.halt) ||
		(wb.valid && wb.halt) || hlt_q;

	// Rises with HLT in write-back and stays up until reset
	assign hlt = hlt_q || (wb.valid && wb.halt);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hlt_q <= 1'b0;
		end else begin
			hlt_q <= hlt;
		end
	end

	// Sticky hlt with nothing completing behind the HLT
	a_hlt_sticky: assert property (
		@(posedge clk) disable iff (!arst_n)
		hlt |=> (hlt && !wb.valid)
	);

endmodule

`default_nettype wire

//--- hw/pipe_reg.sv
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [15:0]
) (
	input  wire logic     clk,
	input  wire logic     arst_n,
	input  wire logic     en,
	input  wire logic     flush,
	input  wire payload_t d,
	output payload_t      q
);

	// Flush wins over hold
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

	// Stage contents stay known once out of reset
	a_q_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(q)
	);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`include "cpu_macros.svh"
`default_nettype none

module reg_file (
	input  wire logic [$clog2(`CPU_NREGS)-1:0] rs_addr,
	input  wire logic [$clog2(`CPU_NREGS)-1:0] rt_addr,
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic                          we,
	input  wire logic [$clog2(`CPU_NREGS)-1:0] wr_addr,
	input  wire logic [`CPU_XLEN-1:0]          wr_data,
	output logic [`CPU_XLEN-1:0]               rs_data,
	output logic [`CPU_XLEN-1:0]               rt_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	// r0 never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Same-cycle write bypass that skips r0
	function automatic logic [`CPU_XLEN-1:0] read_port(logic [$clog2(`CPU_NREGS)-1:0] addr);
		if (we && wr_addr == addr && wr_addr != '0) begin
			return wr_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	// Write protect and bypass keep r0 at zero
	a_r0_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_reg.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/ex_stage.sv
hw/hazard_unit.sv
hw/cpu.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpu_tb -o cpu_sim \
	&& out="$(./obj_dir/cpu_sim)" \
	&& printf '%s\n' "$out" \
	&& printf '%s\n' "$out" | grep -qx "Test passed" \
	&& echo "Simulation passed" \
	|| { echo "Simulation did not pass"; exit 1; }
